/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_riscv_core \
		-f riscv_core.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* alu.sv */
`timescale 1ns/100ps

`include "riscv_core_defs.svh"

module alu (
	input  riscv_pkg::alu_op_e               alu_op_i,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] operand_a_i,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] operand_b_i,
	output logic [`RISCV_WORD_WIDTH - 1 : 0] result_o
);

	localparam int SHAMT_W = $clog2(`RISCV_WORD_WIDTH);

	logic [SHAMT_W - 1 : 0] shamt;

	assign shamt = operand_b_i[SHAMT_W - 1 : 0];

	always_comb
	begin
		result_o = '0;
		case (alu_op_i)
			riscv_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
			riscv_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
			riscv_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
			riscv_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
			riscv_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
			riscv_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
			riscv_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
			riscv_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
			// Compares land in bit zero, which doubles as the branch condition
			riscv_pkg::ALU_SLT:  result_o[0] = $signed(operand_a_i) < $signed(operand_b_i);
			riscv_pkg::ALU_SLTU: result_o[0] = operand_a_i < operand_b_i;
			riscv_pkg::ALU_EQ:   result_o[0] = operand_a_i == operand_b_i;
			riscv_pkg::ALU_NE:   result_o[0] = operand_a_i != operand_b_i;
			riscv_pkg::ALU_GE:   result_o[0] = $signed(operand_a_i) >= $signed(operand_b_i);
			riscv_pkg::ALU_GEU:  result_o[0] = operand_a_i >= operand_b_i;
			default:             result_o = '0;
		endcase
	end

endmodule

/* controller.sv */
`timescale 1ns/100ps

`include "riscv_core_defs.svh"

module controller (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  riscv_pkg::decoded_t              dec_i,
	input  logic                             misaligned_i,
	input  logic                             lsu_done_i,
	input  logic                             branch_taken_i,
	input  logic [`RISCV_ADDR_WIDTH - 1 : 0] target_i,

	output logic                             imem_valid_o,
	input  logic                             imem_ready_i,
	output logic [`RISCV_ADDR_WIDTH - 1 : 0] imem_addr_o,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] imem_rdata_i,

	output logic [`RISCV_WORD_WIDTH - 1 : 0] instr_o,
	output logic [`RISCV_ADDR_WIDTH - 1 : 0] pc_o,
	output logic                             lsu_start_o,
	output logic                             rf_we_o,
	output logic                             halted_o
);

	riscv_pkg::core_state_e           state_q;
	riscv_pkg::core_state_e           state_d;
	logic [`RISCV_ADDR_WIDTH - 1 : 0] pc_q;
	logic [`RISCV_ADDR_WIDTH - 1 : 0] pc_plus4;
	logic [`RISCV_ADDR_WIDTH - 1 : 0] jump_target;
	logic [`RISCV_ADDR_WIDTH - 1 : 0] next_pc;
	logic [`RISCV_WORD_WIDTH - 1 : 0] instr_q;
	logic                             exec_ok;
	logic                             mem_op;
	logic                             in_execute;

	assign mem_op = dec_i.load || dec_i.store;
	assign exec_ok = !dec_i.halt && !misaligned_i;
	assign in_execute = (state_q == riscv_pkg::ST_EXECUTE);

	assign pc_plus4 = pc_q + 32'd4;
	assign jump_target = dec_i.jump_reg ? {target_i[`RISCV_ADDR_WIDTH - 1 : 1], 1'b0} : target_i;
	assign next_pc = (dec_i.jump || (dec_i.branch && branch_taken_i)) ? jump_target : pc_plus4;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			riscv_pkg::ST_FETCH:
			begin
				if (imem_valid_o && imem_ready_i)
				begin
					state_d = riscv_pkg::ST_EXECUTE;
				end
			end
			riscv_pkg::ST_EXECUTE:
			begin
				if (!exec_ok)
				begin
					state_d = riscv_pkg::ST_HALT;
				end
				else
				begin
					state_d = mem_op ? riscv_pkg::ST_MEMORY : riscv_pkg::ST_FETCH;
				end
			end
			riscv_pkg::ST_MEMORY:
			begin
				if (lsu_done_i)
				begin
					state_d = riscv_pkg::ST_FETCH;
				end
			end
			default: state_d = riscv_pkg::ST_HALT;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= riscv_pkg::ST_FETCH;
			pc_q <= `RESET_PC;
			imem_valid_o <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			imem_valid_o <= (state_d == riscv_pkg::ST_FETCH);
			if (in_execute && exec_ok && !mem_op)
			begin
				pc_q <= next_pc;
			end
			else if (state_q == riscv_pkg::ST_MEMORY && lsu_done_i)
			begin
				pc_q <= pc_plus4;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (imem_valid_o && imem_ready_i)
		begin
			instr_q <= imem_rdata_i;
		end
	end

	assign imem_addr_o = pc_q;
	assign pc_o = pc_q;
	assign instr_o = instr_q;
	assign halted_o = (state_q == riscv_pkg::ST_HALT);
	assign lsu_start_o = in_execute && exec_ok && mem_op;

	// Loads write back on the response, everything else in EXECUTE
	assign rf_we_o = dec_i.reg_write &&
		((in_execute && exec_ok && !dec_i.load) ||
		(state_q == riscv_pkg::ST_MEMORY && lsu_done_i));

	// dmem is busy from the cycle after start until done
	a_one_port: assert property (@(posedge clk) disable iff (!arst_n_i)
		imem_valid_o |-> (!lsu_done_i && !$past(lsu_start_o)));

endmodule

/* decoder.sv */
`timescale 1ns/100ps

`include "riscv_core_defs.svh"

module decoder (
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] instr_i,
	input  logic [`RISCV_ADDR_WIDTH - 1 : 0] instr_addr_i,
	output riscv_pkg::decoded_t              dec_o,
	output logic [`RISCV_WORD_WIDTH - 1 : 0] imm_o
);

	logic [2 : 0]                     funct3;
	logic [6 : 0]                     funct7;
	logic [`RISCV_WORD_WIDTH - 1 : 0] imm_i_type;
	logic [`RISCV_WORD_WIDTH - 1 : 0] imm_s_type;
	logic [`RISCV_WORD_WIDTH - 1 : 0] imm_b_type;
	logic [`RISCV_WORD_WIDTH - 1 : 0] imm_u_type;
	logic [`RISCV_WORD_WIDTH - 1 : 0] imm_j_type;

	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb
	begin
		dec_o = '0;
		dec_o.rs1 = instr_i[19:15];
		dec_o.rs2 = instr_i[24:20];
		dec_o.rd = instr_i[11:7];
		dec_o.wb_sel = riscv_pkg::WB_ALU;
		dec_o.alu_op = riscv_pkg::ALU_ADD;
		dec_o.op_a_sel = riscv_pkg::OP_SEL_RF1;
		dec_o.op_b_sel = riscv_pkg::OP_SEL_RF2;
		dec_o.mem_size = riscv_pkg::mem_size_e'(funct3[1:0]);
		dec_o.sign_ext = !funct3[2];
		imm_o = imm_i_type;

		case (riscv_pkg::opcode_e'(instr_i[6:0]))
			riscv_pkg::OPC_OP:
			begin
				dec_o.reg_write = 1'b1;
				dec_o.alu_op = riscv_pkg::alu_op_e'({funct7[5], funct3});
				// Only ADD and SRL have an alternate form
				if (!((funct7 == 7'b0) ||
					((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101))))
				begin
					dec_o.halt = 1'b1;
				end
			end
			riscv_pkg::OPC_OP_IMM:
			begin
				dec_o.reg_write = 1'b1;
				dec_o.op_b_sel = riscv_pkg::OP_SEL_IMM;
				dec_o.alu_op = riscv_pkg::alu_op_e'({1'b0, funct3});
				if (funct3 == 3'b001 && funct7 != 7'b0)
				begin
					dec_o.halt = 1'b1;
				end
				if (funct3 == 3'b101)
				begin
					if (funct7 == 7'b0100000)
					begin
						dec_o.alu_op = riscv_pkg::ALU_SRA;
					end
					else if (funct7 != 7'b0)
					begin
						dec_o.halt = 1'b1;
					end
				end
			end
			riscv_pkg::OPC_LUI:
			begin
				// imm | imm passes the upper immediate through
				dec_o.reg_write = 1'b1;
				dec_o.alu_op = riscv_pkg::ALU_OR;
				dec_o.op_a_sel = riscv_pkg::OP_SEL_IMM;
				dec_o.op_b_sel = riscv_pkg::OP_SEL_IMM;
				imm_o = imm_u_type;
			end
			riscv_pkg::OPC_AUIPC:
			begin
				dec_o.reg_write = 1'b1;
				dec_o.op_a_sel = riscv_pkg::OP_SEL_PC;
				dec_o.op_b_sel = riscv_pkg::OP_SEL_IMM;
				imm_o = imm_u_type;
			end
			riscv_pkg::OPC_JAL:
			begin
				dec_o.reg_write = 1'b1;
				dec_o.wb_sel = riscv_pkg::WB_PC4;
				dec_o.jump = 1'b1;
				dec_o.op_a_sel = riscv_pkg::OP_SEL_PC;
				dec_o.op_b_sel = riscv_pkg::OP_SEL_IMM;
				imm_o = imm_j_type;
			end
			riscv_pkg::OPC_JALR:
			begin
				dec_o.reg_write = 1'b1;
				dec_o.wb_sel = riscv_pkg::WB_PC4;
				dec_o.jump = 1'b1;
				dec_o.jump_reg = 1'b1;
				dec_o.op_b_sel = riscv_pkg::OP_SEL_IMM;
				dec_o.halt = (funct3 != 3'b000);
			end
			riscv_pkg::OPC_BRANCH:
			begin
				dec_o.branch = 1'b1;
				imm_o = imm_b_type;
				case (funct3)
					3'b000:  dec_o.alu_op = riscv_pkg::ALU_EQ;
					3'b001:  dec_o.alu_op = riscv_pkg::ALU_NE;
					3'b100:  dec_o.alu_op = riscv_pkg::ALU_SLT;
					3'b101:  dec_o.alu_op = riscv_pkg::ALU_GE;
					3'b110:  dec_o.alu_op = riscv_pkg::ALU_SLTU;
					3'b111:  dec_o.alu_op = riscv_pkg::ALU_GEU;
					default: dec_o.halt = 1'b1;
				endcase
			end
			riscv_pkg::OPC_LOAD:
			begin
				dec_o.load = 1'b1;
				dec_o.reg_write = 1'b1;
				dec_o.wb_sel = riscv_pkg::WB_LSU;
				dec_o.op_b_sel = riscv_pkg::OP_SEL_IMM;
				dec_o.halt = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			riscv_pkg::OPC_STORE:
			begin
				dec_o.store = 1'b1;
				dec_o.op_b_sel = riscv_pkg::OP_SEL_IMM;
				imm_o = imm_s_type;
				dec_o.halt = funct3[2] || (funct3[1:0] == 2'b11);
			end
			// ECALL stops the core
			riscv_pkg::OPC_SYSTEM: dec_o.halt = 1'b1;
			default:               dec_o.halt = 1'b1;
		endcase

		// No compressed support, so a fetch off a word boundary is illegal
		if (instr_addr_i[1:0] != 2'b00)
		begin
			dec_o.halt = 1'b1;
		end
	end

endmodule

/* lsu.sv */
`timescale 1ns/100ps

`include "riscv_core_defs.svh"

module lsu (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             start_i,
	input  riscv_pkg::decoded_t              dec_i,
	input  logic [`RISCV_ADDR_WIDTH - 1 : 0] addr_i,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] wdata_i,
	output logic                             done_o,
	output logic                             misaligned_o,
	output logic [`RISCV_WORD_WIDTH - 1 : 0] rdata_o,

	output logic                             dmem_valid_o,
	input  logic                             dmem_ready_i,
	output logic [`RISCV_ADDR_WIDTH - 1 : 0] dmem_addr_o,
	output logic [`RISCV_WORD_WIDTH - 1 : 0] dmem_wdata_o,
	output logic [3 : 0]                     dmem_we_o,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] dmem_rdata_i
);

	logic [`RISCV_WORD_WIDTH - 1 : 0] store_lanes;
	logic [3 : 0]                     store_be;
	logic [1 : 0]                     offset_q;
	riscv_pkg::mem_size_e             size_q;
	logic                             sign_q;
	logic [`RISCV_WORD_WIDTH - 1 : 0] load_shifted;

	always_comb
	begin
		case (dec_i.mem_size)
			riscv_pkg::MEM_BYTE:
			begin
				store_lanes = {4{wdata_i[7:0]}};
				store_be = 4'b0001 << addr_i[1:0];
				misaligned_o = 1'b0;
			end
			riscv_pkg::MEM_HALF:
			begin
				store_lanes = {2{wdata_i[15:0]}};
				store_be = 4'b0011 << addr_i[1:0];
				misaligned_o = addr_i[0];
			end
			default:
			begin
				store_lanes = wdata_i;
				store_be = 4'b1111;
				misaligned_o = |addr_i[1:0];
			end
		endcase
		misaligned_o = misaligned_o && (dec_i.load || dec_i.store);
	end

	assign done_o = dmem_valid_o && dmem_ready_i;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			dmem_valid_o <= 1'b0;
			dmem_we_o <= 4'b0;
		end
		else if (start_i)
		begin
			dmem_valid_o <= 1'b1;
			dmem_we_o <= dec_i.store ? store_be : 4'b0;
		end
		else if (done_o)
		begin
			dmem_valid_o <= 1'b0;
			dmem_we_o <= 4'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start_i)
		begin
			dmem_addr_o <= {addr_i[`RISCV_ADDR_WIDTH - 1 : 2], 2'b00};
			dmem_wdata_o <= store_lanes;
			offset_q <= addr_i[1:0];
			size_q <= dec_i.mem_size;
			sign_q <= dec_i.sign_ext;
		end
	end

	// Bring the addressed lane down to bit zero
	assign load_shifted = dmem_rdata_i >> {offset_q, 3'b000};

	always_comb
	begin
		case (size_q)
			riscv_pkg::MEM_BYTE: rdata_o = {{24{sign_q & load_shifted[7]}}, load_shifted[7:0]};
			riscv_pkg::MEM_HALF: rdata_o = {{16{sign_q & load_shifted[15]}}, load_shifted[15:0]};
			default:             rdata_o = load_shifted;
		endcase
	end

	a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		(dmem_valid_o && !dmem_ready_i) |=> $stable(dmem_addr_o));

endmodule

/* reg_file.sv */
`timescale 1ns/100ps

`include "riscv_core_defs.svh"

module reg_file (
	input  logic                                 clk,
	input  logic                                 arst_n_i,
	input  logic [$clog2(`GP_REG_COUNT) - 1 : 0] read_addr_1_i,
	input  logic [$clog2(`GP_REG_COUNT) - 1 : 0] read_addr_2_i,
	output logic [`RISCV_WORD_WIDTH - 1 : 0]     read_data_1_o,
	output logic [`RISCV_WORD_WIDTH - 1 : 0]     read_data_2_o,
	input  logic [$clog2(`GP_REG_COUNT) - 1 : 0] write_addr_i,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0]     write_data_i,
	input  logic                                 write_en_i
);

	logic [`RISCV_WORD_WIDTH - 1 : 0] regs [`GP_REG_COUNT];

	// x0 is never written, so it keeps its reset value
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int i = 0; i < `GP_REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (write_en_i && (write_addr_i != '0))
		begin
			regs[write_addr_i] <= write_data_i;
		end
	end

	assign read_data_1_o = regs[read_addr_1_i];
	assign read_data_2_o = regs[read_addr_2_i];

	a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
		((read_addr_1_i != '0) || (read_data_1_o == '0)) &&
		((read_addr_2_i != '0) || (read_data_2_o == '0)));

endmodule

/* riscv_core.f */
+incdir+.
riscv_pkg.sv
alu.sv
reg_file.sv
decoder.sv
lsu.sv
controller.sv
riscv_core.sv
tb_clk_gen.sv
tb_riscv_core.sv

/* riscv_core.sv */
`timescale 1ns/100ps

`include "riscv_core_defs.svh"

module riscv_core (
	input  logic                             clk,
	input  logic                             arst_n_i,

	output logic                             imem_valid_o,
	input  logic                             imem_ready_i,
	output logic [`RISCV_ADDR_WIDTH - 1 : 0] imem_addr_o,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] imem_rdata_i,

	output logic                             dmem_valid_o,
	input  logic                             dmem_ready_i,
	output logic [`RISCV_ADDR_WIDTH - 1 : 0] dmem_addr_o,
	output logic [`RISCV_WORD_WIDTH - 1 : 0] dmem_wdata_o,
	output logic [3 : 0]                     dmem_we_o,
	input  logic [`RISCV_WORD_WIDTH - 1 : 0] dmem_rdata_i,

	output logic                             halted_o
);

	riscv_pkg::decoded_t              dec;
	logic [`RISCV_WORD_WIDTH - 1 : 0] instr;
	logic [`RISCV_ADDR_WIDTH - 1 : 0] pc;
	logic [`RISCV_WORD_WIDTH - 1 : 0] imm_val;
	logic [`RISCV_WORD_WIDTH - 1 : 0] alu_operand_a;
	logic [`RISCV_WORD_WIDTH - 1 : 0] alu_operand_b;
	logic [`RISCV_WORD_WIDTH - 1 : 0] alu_result;
	logic [`RISCV_WORD_WIDTH - 1 : 0] rf_read_data_1;
	logic [`RISCV_WORD_WIDTH - 1 : 0] rf_read_data_2;
	logic [`RISCV_WORD_WIDTH - 1 : 0] rf_write_data;
	logic                             rf_write_en;
	logic [`RISCV_WORD_WIDTH - 1 : 0] lsu_rdata;
	logic                             lsu_start;
	logic                             lsu_done;
	logic                             lsu_misaligned;
	logic [`RISCV_ADDR_WIDTH - 1 : 0] target_addr;

	// Branches use the ALU for the compare, so their target has its own adder
	assign target_addr = dec.branch ? pc + imm_val : alu_result;

	always_comb
	begin
		case (dec.op_a_sel)
			riscv_pkg::OP_SEL_RF2: alu_operand_a = rf_read_data_2;
			riscv_pkg::OP_SEL_IMM: alu_operand_a = imm_val;
			riscv_pkg::OP_SEL_PC:  alu_operand_a = pc;
			default:               alu_operand_a = rf_read_data_1;
		endcase

		case (dec.op_b_sel)
			riscv_pkg::OP_SEL_RF1: alu_operand_b = rf_read_data_1;
			riscv_pkg::OP_SEL_IMM: alu_operand_b = imm_val;
			riscv_pkg::OP_SEL_PC:  alu_operand_b = pc;
			default:               alu_operand_b = rf_read_data_2;
		endcase

		case (dec.wb_sel)
			riscv_pkg::WB_LSU: rf_write_data = lsu_rdata;
			riscv_pkg::WB_PC4: rf_write_data = pc + 32'd4;
			default:           rf_write_data = alu_result;
		endcase
	end

	alu alu (
		.alu_op_i    (dec.alu_op),
		.operand_a_i (alu_operand_a),
		.operand_b_i (alu_operand_b),
		.result_o    (alu_result)
	);

	reg_file reg_file (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.read_addr_1_i (dec.rs1),
		.read_addr_2_i (dec.rs2),
		.read_data_1_o (rf_read_data_1),
		.read_data_2_o (rf_read_data_2),
		.write_addr_i  (dec.rd),
		.write_data_i  (rf_write_data),
		.write_en_i    (rf_write_en)
	);

	decoder decoder (
		.instr_i      (instr),
		.instr_addr_i (pc),
		.dec_o        (dec),
		.imm_o        (imm_val)
	);

	lsu lsu (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.start_i      (lsu_start),
		.dec_i        (dec),
		.addr_i       (alu_result),
		.wdata_i      (rf_read_data_2),
		.done_o       (lsu_done),
		.misaligned_o (lsu_misaligned),
		.rdata_o      (lsu_rdata),
		.dmem_valid_o (dmem_valid_o),
		.dmem_ready_i (dmem_ready_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_rdata_i (dmem_rdata_i)
	);

	controller controller (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.dec_i          (dec),
		.misaligned_i   (lsu_misaligned),
		.lsu_done_i     (lsu_done),
		.branch_taken_i (alu_result[0]),
		.target_i       (target_addr),
		.imem_valid_o   (imem_valid_o),
		.imem_ready_i   (imem_ready_i),
		.imem_addr_o    (imem_addr_o),
		.imem_rdata_i   (imem_rdata_i),
		.instr_o        (instr),
		.pc_o           (pc),
		.lsu_start_o    (lsu_start),
		.rf_we_o        (rf_write_en),
		.halted_o       (halted_o)
	);

endmodule

/* riscv_core_defs.svh */
`ifndef RISCV_CORE_DEFS_SVH
`define RISCV_CORE_DEFS_SVH

// Datapath word width in bits
`define RISCV_WORD_WIDTH 32

// Byte address width
`define RISCV_ADDR_WIDTH 32

// General purpose registers, x0 included
`define GP_REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* riscv_pkg.sv */
`include "riscv_core_defs.svh"

package riscv_pkg;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// Low three bits follow funct3, bit 3 follows funct7[5] for SUB and SRA
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_EQ   = 4'b1001,
		ALU_NE   = 4'b1010,
		ALU_GE   = 4'b1011,
		ALU_GEU  = 4'b1100,
		ALU_SRA  = 4'b1101
	} alu_op_e;

	typedef enum logic [1:0] {OP_SEL_RF1, OP_SEL_RF2, OP_SEL_IMM, OP_SEL_PC} op_sel_e;

	typedef enum logic [1:0] {WB_ALU, WB_LSU, WB_PC4} wb_sel_e;

	// Encoding matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

	typedef enum logic [1:0] {ST_FETCH, ST_EXECUTE, ST_MEMORY, ST_HALT} core_state_e;

	typedef struct packed {
		logic [$clog2(`GP_REG_COUNT) - 1 : 0] rs1;
		logic [$clog2(`GP_REG_COUNT) - 1 : 0] rs2;
		logic [$clog2(`GP_REG_COUNT) - 1 : 0] rd;
		logic                                 reg_write;
		wb_sel_e                              wb_sel;
		alu_op_e                              alu_op;
		op_sel_e                              op_a_sel;
		op_sel_e                              op_b_sel;
		logic                                 load;
		logic                                 store;
		mem_size_e                            mem_size;
		logic                                 sign_ext;
		logic                                 jump;
		logic                                 jump_reg;
		logic                                 branch;
		logic                                 halt;
	} decoded_t;

endpackage

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter real PERIOD_NS = 40.0
) (
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2.0) clk_o = ~clk_o;
		end
	end

endmodule

/* tb_riscv_core.sv */
`timescale 1ns/100ps

module tb_riscv_core;

	localparam int STORE_COUNT = 19;
	localparam int TIMEOUT_CYCLES = 4000;

	localparam logic [6:0] op_reg = 7'h33;
	localparam logic [6:0] op_imm = 7'h13;
	localparam logic [6:0] op_load = 7'h03;
	localparam logic [6:0] op_store = 7'h23;
	localparam logic [6:0] op_branch = 7'h63;
	localparam logic [6:0] op_jal = 7'h6f;
	localparam logic [6:0] op_jalr = 7'h67;
	localparam logic [6:0] op_lui = 7'h37;
	localparam logic [6:0] op_auipc = 7'h17;
	localparam logic [6:0] op_system = 7'h73;

	// BEQ, BNE, BLT, BGE, BLTU, BGEU with x2 = -7 and x3 = 5
	localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	localparam logic [4:0] tk_rs1 [6] = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd3, 5'd2};
	localparam logic [4:0] tk_rs2 [6] = '{5'd3, 5'd3, 5'd3, 5'd2, 5'd2, 5'd3};
	localparam logic [4:0] nt_rs1 [6] = '{5'd2, 5'd3, 5'd3, 5'd2, 5'd2, 5'd3};
	localparam logic [4:0] nt_rs2 [6] = '{5'd3, 5'd3, 5'd2, 5'd3, 5'd3, 5'd2};

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  be;
		logic [31:0] data;
	} store_t;

	logic        clk;
	logic        arst_n;
	logic        imem_valid_o;
	logic        imem_ready_i;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_rdata_i;
	logic        dmem_valid_o;
	logic        dmem_ready_i;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_wdata_o;
	logic [3:0]  dmem_we_o;
	logic [31:0] dmem_rdata_i;
	logic        halted_o;

	logic [31:0] mem [256];
	store_t      exp_store [STORE_COUNT];
	int          exp_fill = 0;
	int          prog_len = 0;
	int          store_idx = 0;
	int          error_count = 0;
	int          imem_wait;
	int          dmem_wait;
	integer      seed;

	tb_clk_gen clk_gen_inst (
		.clk_o (clk)
	);

	riscv_core riscv_core_inst (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.imem_valid_o (imem_valid_o),
		.imem_ready_i (imem_ready_i),
		.imem_addr_o  (imem_addr_o),
		.imem_rdata_i (imem_rdata_i),
		.dmem_valid_o (dmem_valid_o),
		.dmem_ready_i (dmem_ready_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_rdata_i (dmem_rdata_i),
		.halted_o     (halted_o)
	);

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	function automatic logic [31:0] lane_mask(input logic [3:0] be);
		logic [31:0] mask;
		for (int b = 0; b < 4; b++)
		begin
			mask[b * 8 +: 8] = {8{be[b]}};
		end
		return mask;
	endfunction

	task automatic put_instr(input logic [31:0] word);
		mem[prog_len] = word;
		prog_len++;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [3:0] be,
		input logic [31:0] data);
		exp_store[exp_fill] = {addr, be, data};
		exp_fill++;
	endtask

	task automatic load_program();
		for (int i = 0; i < 256; i++)
		begin
			mem[i] = 32'hc0de_0000 | i;
		end
		put_instr(itype(12'h200, 5'd0, 3'd0, 5'd1, op_imm));
		put_instr(itype(-12'd7, 5'd0, 3'd0, 5'd2, op_imm));
		put_instr(itype(12'd5, 5'd0, 3'd0, 5'd3, op_imm));
		put_instr(rtype(7'h00, 5'd3, 5'd2, 3'd0, 5'd4));
		put_instr(stype(12'd0, 5'd4, 5'd1, 3'd2));
		put_instr(rtype(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
		put_instr(stype(12'd4, 5'd4, 5'd1, 3'd2));
		put_instr(itype(12'h401, 5'd2, 3'd5, 5'd4, op_imm));
		put_instr(stype(12'd8, 5'd4, 5'd1, 3'd2));
		put_instr(rtype(7'h00, 5'd3, 5'd2, 3'd5, 5'd4));
		put_instr(stype(12'd12, 5'd4, 5'd1, 3'd2));
		put_instr(rtype(7'h00, 5'd3, 5'd3, 3'd1, 5'd4));
		put_instr(rtype(7'h00, 5'd2, 5'd4, 3'd4, 5'd4));
		put_instr(stype(12'd16, 5'd4, 5'd1, 3'd2));
		put_instr(itype(12'h0f0, 5'd2, 3'd7, 5'd5, op_imm));
		put_instr(rtype(7'h00, 5'd5, 5'd3, 3'd6, 5'd4));
		put_instr(stype(12'd20, 5'd4, 5'd1, 3'd2));
		// SLT, SLTU and SLTIU packed into one word
		put_instr(rtype(7'h00, 5'd3, 5'd2, 3'd2, 5'd4));
		put_instr(rtype(7'h00, 5'd3, 5'd2, 3'd3, 5'd5));
		put_instr(itype(12'hfff, 5'd3, 3'd3, 5'd6, op_imm));
		put_instr(itype(12'd8, 5'd4, 3'd1, 5'd4, op_imm));
		put_instr(itype(12'd4, 5'd5, 3'd1, 5'd5, op_imm));
		put_instr(rtype(7'h00, 5'd5, 5'd4, 3'd0, 5'd4));
		put_instr(rtype(7'h00, 5'd6, 5'd4, 3'd0, 5'd4));
		put_instr(stype(12'd24, 5'd4, 5'd1, 3'd2));
		put_instr(utype(20'h12345, 5'd4, op_lui));
		put_instr(utype(20'h00001, 5'd5, op_auipc));
		put_instr(rtype(7'h00, 5'd5, 5'd4, 3'd0, 5'd4));
		put_instr(stype(12'd28, 5'd4, 5'd1, 3'd2));
		put_instr(itype(12'd0, 5'd0, 3'd0, 5'd7, op_imm));
		// Taken branch hops a stray store, untaken one falls into a count of x7
		for (int k = 0; k < 6; k++)
		begin
			put_instr(btype(13'd8, tk_rs2[k], tk_rs1[k], br_f3[k]));
			put_instr(stype(12'd124, 5'd0, 5'd1, 3'd2));
			put_instr(btype(13'd8, nt_rs2[k], nt_rs1[k], br_f3[k]));
			put_instr(itype(12'd1, 5'd7, 3'd0, 5'd7, op_imm));
		end
		put_instr(stype(12'd32, 5'd7, 5'd1, 3'd2));
		put_instr(jtype(21'd8, 5'd8));
		put_instr(stype(12'd124, 5'd0, 5'd1, 3'd2));
		put_instr(stype(12'd36, 5'd8, 5'd1, 3'd2));
		put_instr(itype(12'h0f4, 5'd0, 3'd0, 5'd9, op_imm));
		put_instr(itype(12'd5, 5'd9, 3'd0, 5'd10, op_jalr));
		put_instr(stype(12'd124, 5'd0, 5'd1, 3'd2));
		put_instr(stype(12'd124, 5'd0, 5'd1, 3'd2));
		put_instr(stype(12'd40, 5'd10, 5'd1, 3'd2));
		put_instr(utype(20'h89abd, 5'd11, op_lui));
		put_instr(itype(-12'h211, 5'd11, 3'd0, 5'd11, op_imm));
		put_instr(stype(12'd44, 5'd11, 5'd1, 3'd2));
		put_instr(stype(12'd49, 5'd11, 5'd1, 3'd0));
		put_instr(stype(12'd50, 5'd11, 5'd1, 3'd1));
		put_instr(itype(12'd48, 5'd1, 3'd0, 5'd12, op_load));
		put_instr(itype(12'd49, 5'd1, 3'd4, 5'd13, op_load));
		put_instr(itype(12'd50, 5'd1, 3'd1, 5'd14, op_load));
		put_instr(itype(12'd50, 5'd1, 3'd5, 5'd15, op_load));
		put_instr(itype(12'd48, 5'd1, 3'd2, 5'd16, op_load));
		put_instr(stype(12'd52, 5'd12, 5'd1, 3'd2));
		put_instr(stype(12'd56, 5'd13, 5'd1, 3'd2));
		put_instr(stype(12'd60, 5'd14, 5'd1, 3'd2));
		put_instr(stype(12'd64, 5'd15, 5'd1, 3'd2));
		put_instr(stype(12'd68, 5'd16, 5'd1, 3'd2));
		put_instr(itype(12'd0, 5'd0, 3'd0, 5'd0, op_system));
	endtask

	task automatic load_expected();
		expect_store(32'h200, 4'hf, 32'hffff_fffe);
		expect_store(32'h204, 4'hf, 32'h0000_000c);
		expect_store(32'h208, 4'hf, 32'hffff_fffc);
		expect_store(32'h20c, 4'hf, 32'h07ff_ffff);
		expect_store(32'h210, 4'hf, 32'hffff_ff59);
		expect_store(32'h214, 4'hf, 32'h0000_00f5);
		expect_store(32'h218, 4'hf, 32'h0000_0101);
		expect_store(32'h21c, 4'hf, 32'h1234_6068);
		expect_store(32'h220, 4'hf, 32'h0000_0006);
		// Link values of JAL and JALR
		expect_store(32'h224, 4'hf, 32'h0000_00e0);
		expect_store(32'h228, 4'hf, 32'h0000_00f0);
		expect_store(32'h22c, 4'hf, 32'h89ab_cdef);
		expect_store(32'h230, 4'h2, 32'h0000_ef00);
		expect_store(32'h230, 4'hc, 32'hcdef_0000);
		// Word 0x230 now reads cdef_ef8c
		expect_store(32'h234, 4'hf, 32'hffff_ff8c);
		expect_store(32'h238, 4'hf, 32'h0000_00ef);
		expect_store(32'h23c, 4'hf, 32'hffff_cdef);
		expect_store(32'h240, 4'hf, 32'h0000_cdef);
		expect_store(32'h244, 4'hf, 32'hcdef_ef8c);
	endtask

	// Both ports answer on the falling edge after 0 to 3 cycles
	always @(negedge clk)
	begin
		if (imem_ready_i)
		begin
			imem_ready_i = 1'b0;
			imem_wait = $unsigned($random(seed)) % 4;
		end
		else if (imem_valid_o)
		begin
			if (imem_wait == 0)
			begin
				imem_rdata_i = mem[imem_addr_o[9:2]];
				imem_ready_i = 1'b1;
			end
			else
			begin
				imem_wait--;
			end
		end

		if (dmem_ready_i)
		begin
			dmem_ready_i = 1'b0;
			dmem_wait = $unsigned($random(seed)) % 4;
		end
		else if (dmem_valid_o)
		begin
			if (dmem_wait == 0)
			begin
				for (int b = 0; b < 4; b++)
				begin
					if (dmem_we_o[b])
					begin
						mem[dmem_addr_o[9:2]][b * 8 +: 8] = dmem_wdata_o[b * 8 +: 8];
					end
				end
				dmem_rdata_i = mem[dmem_addr_o[9:2]];
				dmem_ready_i = 1'b1;
			end
			else
			begin
				dmem_wait--;
			end
		end
	end

	always @(posedge clk)
	begin
		if (arst_n && dmem_valid_o && dmem_ready_i && (dmem_we_o != 4'b0))
		begin
			store_idx <= store_idx + 1;
		end
	end

	a_reset_idle: assert property (@(posedge clk)
		!arst_n |-> (!imem_valid_o && !dmem_valid_o && (dmem_we_o == 4'b0) && !halted_o))
	else
	begin
		error_count++;
		$display("outputs not idle during reset at %0t", $time);
	end

	a_first_fetch: assert property (@(posedge clk)
		$rose(arst_n) |=> (imem_valid_o && (imem_addr_o == 32'h0)))
	else
	begin
		error_count++;
		$display("first fetch from address 0 missing after reset at %0t", $time);
	end

	a_imem_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(imem_valid_o && !imem_ready_i) |=> (imem_valid_o && $stable(imem_addr_o)))
	else
	begin
		error_count++;
		$display("instruction request dropped or changed before ready at %0t", $time);
	end

	a_dmem_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(dmem_valid_o && !dmem_ready_i) |=> (dmem_valid_o && $stable(dmem_addr_o) &&
		$stable(dmem_wdata_o) && $stable(dmem_we_o)))
	else
	begin
		error_count++;
		$display("data request dropped or changed before ready at %0t", $time);
	end

	a_one_port: assert property (@(posedge clk) disable iff (!arst_n)
		!(imem_valid_o && dmem_valid_o))
	else
	begin
		error_count++;
		$display("both memory ports requested at once at %0t", $time);
	end

	a_store: assert property (@(posedge clk) disable iff (!arst_n)
		(dmem_valid_o && dmem_ready_i && (dmem_we_o != 4'b0)) |->
		((store_idx < STORE_COUNT) && (dmem_addr_o == exp_store[store_idx].addr) &&
		(dmem_we_o == exp_store[store_idx].be) &&
		((dmem_wdata_o & lane_mask(dmem_we_o)) == exp_store[store_idx].data)))
	else
	begin
		error_count++;
		$display("mismatch at %0t: store %0d addr %h we %b data %h", $time,
			$sampled(store_idx), $sampled(dmem_addr_o), $sampled(dmem_we_o),
			$sampled(dmem_wdata_o));
	end

	a_halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		halted_o |-> (!imem_valid_o && !dmem_valid_o))
	else
	begin
		error_count++;
		$display("core issued a memory request while halted at %0t", $time);
	end

	a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		halted_o |=> halted_o)
	else
	begin
		error_count++;
		$display("core left halt at %0t", $time);
	end

	initial
	begin
		int cycles;

		seed = 32'h67df;
		arst_n = 1'b0;
		imem_ready_i = 1'b0;
		imem_rdata_i = '0;
		dmem_ready_i = 1'b0;
		dmem_rdata_i = '0;
		imem_wait = $unsigned($random(seed)) % 4;
		dmem_wait = $unsigned($random(seed)) % 4;
		load_program();
		load_expected();

		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		cycles = 0;
		while (!halted_o && (cycles < TIMEOUT_CYCLES))
		begin
			@(negedge clk);
			cycles++;
		end

		if (!halted_o)
		begin
			error_count++;
			$display("timeout: halted_o not seen within %0d cycles", TIMEOUT_CYCLES);
		end
		else
		begin
			// Watch the halted core for a few more cycles
			repeat (10) @(negedge clk);
			if (store_idx != STORE_COUNT)
			begin
				error_count++;
				$display("mismatch at %0t: %0d stores seen, %0d expected", $time,
					store_idx, STORE_COUNT);
			end
		end

		$display("stores %0d of %0d, errors %0d", store_idx, STORE_COUNT, error_count);
		if (error_count == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
